/* hw/oflow_reg_pkg.sv */
//----------------------------------------------------------
// register map and configuration field widths
// one 32-bit word per register, byte addressed
// fields sit in the low bits, upper bits read back as zero
//----------------------------------------------------------
`default_nettype none

package oflow_reg_pkg;

	// apb bus widths
	localparam int ADDR_LEN = 8;
	localparam int DATA_LEN = 32;

	// configuration field widths
	localparam int WEIGHT_LEN = 8;
	localparam int SCORE_LEN = 20;
	localparam int NUM_OF_HISTORY_FRAMES_WIDTH = 8;
	localparam int MAX_THRESHOLD_FOR_CONFLICTS_LEN = 4;

	// number of mapped registers
	localparam int NUM_REGS = 9;

	//----------------------------------------------------------
	// register addresses
	//----------------------------------------------------------
	localparam logic [ADDR_LEN-1:0] W_IOU_ADDR = 8'h00;
	localparam logic [ADDR_LEN-1:0] W_WIDTH_ADDR = 8'h04;
	localparam logic [ADDR_LEN-1:0] W_HEIGHT_ADDR = 8'h08;
	localparam logic [ADDR_LEN-1:0] W_COLOR1_ADDR = 8'h0C;
	localparam logic [ADDR_LEN-1:0] W_COLOR2_ADDR = 8'h10;
	localparam logic [ADDR_LEN-1:0] W_HISTORY_ADDR = 8'h14;
	localparam logic [ADDR_LEN-1:0] SCORE_TH_FOR_NEW_BBOX_ADDR = 8'h18;
	localparam logic [ADDR_LEN-1:0] NUM_OF_HISTORY_FRAMES_ADDR = 8'h1C;
	localparam logic [ADDR_LEN-1:0] MAX_THRESHOLD_FOR_CONFLICTS_ADDR = 8'h20;

endpackage

`default_nettype wire

/* hw/oflow_bbox_pkg.sv */
//----------------------------------------------------------
// bounding box feature and candidate widths
// at most 16 candidates per detection
// all features are unsigned 8-bit values
//----------------------------------------------------------
`default_nettype none

package oflow_bbox_pkg;

	// width, height, color, iou cost and age fields
	localparam int FEATURE_LEN = 8;

	// candidate index within one detection
	localparam int CAND_IDX_LEN = 4;

	// live candidate count, must hold the full 16
	localparam int LIVE_CNT_LEN = CAND_IDX_LEN + 1;

	// one weight times one feature
	localparam int PRODUCT_LEN = 16;

	// number of weighted terms summed per pair
	localparam int NUM_TERMS = 6;

	// six full-scale products still fit in a score
	// 6 * 255 * 255 = 390150 < 2**20

endpackage

`default_nettype wire

/* hw/oflow_weights_if.sv */
//----------------------------------------------------------
// configuration bundle from the register file to the core
// values are static while pairs are in flight
//----------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

interface oflow_weights_if
	import oflow_reg_pkg::*;
();

	// per-term weights
	logic [WEIGHT_LEN-1:0] w_iou;
	logic [WEIGHT_LEN-1:0] w_width;
	logic [WEIGHT_LEN-1:0] w_height;
	logic [WEIGHT_LEN-1:0] w_color1;
	logic [WEIGHT_LEN-1:0] w_color2;
	logic [WEIGHT_LEN-1:0] w_history;

	// selection thresholds
	logic [SCORE_LEN-1:0] score_th_for_new_bbox;
	logic [NUM_OF_HISTORY_FRAMES_WIDTH-1:0] num_of_history_frames;
	logic [MAX_THRESHOLD_FOR_CONFLICTS_LEN-1:0] max_threshold_for_conflicts;

	modport reg_side (
		output w_iou, w_width, w_height, w_color1, w_color2, w_history,
		output score_th_for_new_bbox, num_of_history_frames, max_threshold_for_conflicts
	);

	modport core_side (
		input w_iou, w_width, w_height, w_color1, w_color2, w_history,
		input score_th_for_new_bbox, num_of_history_frames, max_threshold_for_conflicts
	);

endinterface

`default_nettype wire

/* hw/oflow_reg_file.sv */
//----------------------------------------------------------
// apb slave with nine configuration registers
// zero wait states, pready follows psel and penable
// unmapped address gives pslverr, read zero, no write
// write data is truncated to the field width
//----------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module oflow_reg_file
	import oflow_reg_pkg::*;
(
	input  logic                clk,
	input  logic                reset_N,
	input  logic                apb_psel,
	input  logic                apb_penable,
	input  logic                apb_pwrite,
	input  logic [ADDR_LEN-1:0] apb_addr,
	input  logic [DATA_LEN-1:0] apb_pwdata,
	output logic [DATA_LEN-1:0] apb_prdata,
	output logic                apb_pready,
	output logic                apb_pslverr,
	oflow_weights_if.reg_side   cfg
);

	//----------------------------------------------------------
	// registers and decode
	//----------------------------------------------------------
	logic access;
	logic wr_en;
	logic rd_en;
	logic [NUM_REGS-1:0] hit;
	logic [NUM_REGS-1:0] wr_hit;

	logic [WEIGHT_LEN-1:0] w_iou_reg;
	logic [WEIGHT_LEN-1:0] w_width_reg;
	logic [WEIGHT_LEN-1:0] w_height_reg;
	logic [WEIGHT_LEN-1:0] w_color1_reg;
	logic [WEIGHT_LEN-1:0] w_color2_reg;
	logic [WEIGHT_LEN-1:0] w_history_reg;
	logic [SCORE_LEN-1:0] score_th_reg;
	logic [NUM_OF_HISTORY_FRAMES_WIDTH-1:0] hist_frames_reg;
	logic [MAX_THRESHOLD_FOR_CONFLICTS_LEN-1:0] max_conflicts_reg;

	// access phase
	assign access = apb_psel && apb_penable;
	assign wr_en = access && apb_pwrite;
	assign rd_en = access && !apb_pwrite;

	// one bit per register, in address order
	assign hit[0] = (apb_addr == W_IOU_ADDR);
	assign hit[1] = (apb_addr == W_WIDTH_ADDR);
	assign hit[2] = (apb_addr == W_HEIGHT_ADDR);
	assign hit[3] = (apb_addr == W_COLOR1_ADDR);
	assign hit[4] = (apb_addr == W_COLOR2_ADDR);
	assign hit[5] = (apb_addr == W_HISTORY_ADDR);
	assign hit[6] = (apb_addr == SCORE_TH_FOR_NEW_BBOX_ADDR);
	assign hit[7] = (apb_addr == NUM_OF_HISTORY_FRAMES_ADDR);
	assign hit[8] = (apb_addr == MAX_THRESHOLD_FOR_CONFLICTS_ADDR);

	assign wr_hit = hit & {NUM_REGS{wr_en}};

	// never waits
	assign apb_pready = access;
	assign apb_pslverr = access && (hit == '0);

	//----------------------------------------------------------
	// write path
	//----------------------------------------------------------
	always_ff @(posedge clk or negedge reset_N)
	begin
		if (!reset_N)
		begin
			w_iou_reg <= '0;
			w_width_reg <= '0;
			w_height_reg <= '0;
			w_color1_reg <= '0;
			w_color2_reg <= '0;
			w_history_reg <= '0;
			score_th_reg <= '0;
			hist_frames_reg <= '0;
			max_conflicts_reg <= '0;
		end
		else
		begin
			if (wr_hit[0])
				w_iou_reg <= apb_pwdata[WEIGHT_LEN-1:0];
			if (wr_hit[1])
				w_width_reg <= apb_pwdata[WEIGHT_LEN-1:0];
			if (wr_hit[2])
				w_height_reg <= apb_pwdata[WEIGHT_LEN-1:0];
			if (wr_hit[3])
				w_color1_reg <= apb_pwdata[WEIGHT_LEN-1:0];
			if (wr_hit[4])
				w_color2_reg <= apb_pwdata[WEIGHT_LEN-1:0];
			if (wr_hit[5])
				w_history_reg <= apb_pwdata[WEIGHT_LEN-1:0];
			if (wr_hit[6])
				score_th_reg <= apb_pwdata[SCORE_LEN-1:0];
			if (wr_hit[7])
				hist_frames_reg <= apb_pwdata[NUM_OF_HISTORY_FRAMES_WIDTH-1:0];
			if (wr_hit[8])
				max_conflicts_reg <= apb_pwdata[MAX_THRESHOLD_FOR_CONFLICTS_LEN-1:0];
		end
	end

	//----------------------------------------------------------
	// read path
	//----------------------------------------------------------
	// and-or mux, hits are one-hot, zero when nothing hits
	always_comb
	begin
		apb_prdata = '0;
		if (rd_en)
		begin
			apb_prdata = ({DATA_LEN{hit[0]}} & DATA_LEN'(w_iou_reg))
				| ({DATA_LEN{hit[1]}} & DATA_LEN'(w_width_reg))
				| ({DATA_LEN{hit[2]}} & DATA_LEN'(w_height_reg))
				| ({DATA_LEN{hit[3]}} & DATA_LEN'(w_color1_reg))
				| ({DATA_LEN{hit[4]}} & DATA_LEN'(w_color2_reg))
				| ({DATA_LEN{hit[5]}} & DATA_LEN'(w_history_reg))
				| ({DATA_LEN{hit[6]}} & DATA_LEN'(score_th_reg))
				| ({DATA_LEN{hit[7]}} & DATA_LEN'(hist_frames_reg))
				| ({DATA_LEN{hit[8]}} & DATA_LEN'(max_conflicts_reg));
		end
	end

	// configuration out to the core
	assign cfg.w_iou = w_iou_reg;
	assign cfg.w_width = w_width_reg;
	assign cfg.w_height = w_height_reg;
	assign cfg.w_color1 = w_color1_reg;
	assign cfg.w_color2 = w_color2_reg;
	assign cfg.w_history = w_history_reg;
	assign cfg.score_th_for_new_bbox = score_th_reg;
	assign cfg.num_of_history_frames = hist_frames_reg;
	assign cfg.max_threshold_for_conflicts = max_conflicts_reg;

	// registers hold across a slave error
	a_err_no_hit: assert property (@(posedge clk) disable iff (!reset_N)
		apb_pslverr |=> $stable({w_iou_reg, w_width_reg, w_height_reg,
			w_color1_reg, w_color2_reg, w_history_reg, score_th_reg, hist_frames_reg,
			max_conflicts_reg}));

	// at most one register written per cycle
	a_one_write: assert property (@(posedge clk) disable iff (!reset_N)
		$onehot0(wr_hit));

endmodule

`default_nettype wire

/* hw/oflow_score_calc.sv */
//----------------------------------------------------------
// two-stage weighted match score per candidate pair
// score_valid follows pair_valid by exactly two cycles
// weights are sampled in stage 2, keep them stable in flight
//----------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module oflow_score_calc
	import oflow_reg_pkg::*;
	import oflow_bbox_pkg::*;
(
	input  logic                    clk,
	input  logic                    reset_N,
	input  logic                    pair_valid,
	input  logic                    pair_last,
	input  logic [FEATURE_LEN-1:0]  cur_w,
	input  logic [FEATURE_LEN-1:0]  cur_h,
	input  logic [FEATURE_LEN-1:0]  cur_c1,
	input  logic [FEATURE_LEN-1:0]  cur_c2,
	input  logic [FEATURE_LEN-1:0]  prev_w,
	input  logic [FEATURE_LEN-1:0]  prev_h,
	input  logic [FEATURE_LEN-1:0]  prev_c1,
	input  logic [FEATURE_LEN-1:0]  prev_c2,
	input  logic [FEATURE_LEN-1:0]  iou_cost,
	input  logic [FEATURE_LEN-1:0]  hist_age,
	oflow_weights_if.core_side      cfg,
	output logic                    score_valid,
	output logic                    score_last,
	output logic [SCORE_LEN-1:0]    score,
	output logic                    expired,
	output logic [CAND_IDX_LEN-1:0] score_index
);

	function automatic logic [FEATURE_LEN-1:0] abs_diff(
		input logic [FEATURE_LEN-1:0] a,
		input logic [FEATURE_LEN-1:0] b
	);
		return (a > b) ? (a - b) : (b - a);
	endfunction

	//----------------------------------------------------------
	// stage 1, differences and candidate index
	//----------------------------------------------------------
	logic s1_valid;
	logic s1_last;
	logic [CAND_IDX_LEN-1:0] cand_cnt;
	logic [CAND_IDX_LEN-1:0] s1_idx;
	logic [FEATURE_LEN-1:0] s1_dw;
	logic [FEATURE_LEN-1:0] s1_dh;
	logic [FEATURE_LEN-1:0] s1_dc1;
	logic [FEATURE_LEN-1:0] s1_dc2;
	logic [FEATURE_LEN-1:0] s1_iou;
	logic [FEATURE_LEN-1:0] s1_age;

	// weighted terms, one per feature
	logic [PRODUCT_LEN-1:0] prod [NUM_TERMS];

	always_ff @(posedge clk or negedge reset_N)
	begin
		if (!reset_N)
		begin
			s1_valid <= 1'b0;
			s1_last <= 1'b0;
			cand_cnt <= '0;
		end
		else
		begin
			s1_valid <= pair_valid;
			s1_last <= pair_valid && pair_last;
			// restart numbering with the next detection
			if (pair_valid)
				cand_cnt <= pair_last ? '0 : cand_cnt + 1'b1;
		end
	end

	// feature payload
	always_ff @(posedge clk)
	begin
		if (pair_valid)
		begin
			s1_idx <= cand_cnt;
			s1_dw <= abs_diff(cur_w, prev_w);
			s1_dh <= abs_diff(cur_h, prev_h);
			s1_dc1 <= abs_diff(cur_c1, prev_c1);
			s1_dc2 <= abs_diff(cur_c2, prev_c2);
			s1_iou <= iou_cost;
			s1_age <= hist_age;
		end
	end

	//----------------------------------------------------------
	// stage 2, weight, sum and expiry
	//----------------------------------------------------------
	assign prod[0] = PRODUCT_LEN'(cfg.w_width) * PRODUCT_LEN'(s1_dw);
	assign prod[1] = PRODUCT_LEN'(cfg.w_height) * PRODUCT_LEN'(s1_dh);
	assign prod[2] = PRODUCT_LEN'(cfg.w_color1) * PRODUCT_LEN'(s1_dc1);
	assign prod[3] = PRODUCT_LEN'(cfg.w_color2) * PRODUCT_LEN'(s1_dc2);
	assign prod[4] = PRODUCT_LEN'(cfg.w_iou) * PRODUCT_LEN'(s1_iou);
	assign prod[5] = PRODUCT_LEN'(cfg.w_history) * PRODUCT_LEN'(s1_age);

	always_ff @(posedge clk or negedge reset_N)
	begin
		if (!reset_N)
		begin
			score_valid <= 1'b0;
			score_last <= 1'b0;
		end
		else
		begin
			score_valid <= s1_valid;
			score_last <= s1_valid && s1_last;
		end
	end

	// widened sum, no overflow possible
	always_ff @(posedge clk)
	begin
		if (s1_valid)
		begin
			score <= SCORE_LEN'(prod[0]) + SCORE_LEN'(prod[1]) + SCORE_LEN'(prod[2])
				+ SCORE_LEN'(prod[3]) + SCORE_LEN'(prod[4]) + SCORE_LEN'(prod[5]);
			expired <= (s1_age >= cfg.num_of_history_frames);
			score_index <= s1_idx;
		end
	end

	// two-cycle latency, last flag travels with its pair
	a_latency: assert property (@(posedge clk) disable iff (!reset_N)
		pair_valid |-> ##2 (score_valid && (score_last == $past(pair_last, 2))));

endmodule

`default_nettype wire

/* hw/oflow_match_select.sv */
//----------------------------------------------------------
// per-detection minimum search over scored candidates
// expired candidates never win and are not counted
// result pulses one cycle after the last score
//----------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module oflow_match_select
	import oflow_reg_pkg::*;
	import oflow_bbox_pkg::*;
(
	input  logic                    clk,
	input  logic                    reset_N,
	input  logic                    score_valid,
	input  logic                    score_last,
	input  logic [SCORE_LEN-1:0]    score,
	input  logic                    expired,
	input  logic [CAND_IDX_LEN-1:0] score_index,
	oflow_weights_if.core_side      cfg,
	output logic                    match_valid,
	output logic [CAND_IDX_LEN-1:0] match_index,
	output logic                    new_bbox,
	output logic                    conflict
);

	//----------------------------------------------------------
	// running state of the current detection
	//----------------------------------------------------------
	logic live;
	logic take;
	logic below_th;
	logic found;
	logic nxt_found;
	logic [LIVE_CNT_LEN-1:0] live_cnt;
	logic [LIVE_CNT_LEN-1:0] nxt_cnt;
	logic [SCORE_LEN-1:0] best_score;
	logic [SCORE_LEN-1:0] nxt_score;
	logic [CAND_IDX_LEN-1:0] best_idx;
	logic [CAND_IDX_LEN-1:0] nxt_idx;

	assign live = !expired;
	// strict compare, earlier index keeps a tie
	assign take = live && (!found || (score < best_score));
	assign below_th = live && (score < cfg.score_th_for_new_bbox);

	// state including the incoming candidate
	assign nxt_found = found || live;
	assign nxt_score = take ? score : best_score;
	assign nxt_idx = take ? score_index : best_idx;
	assign nxt_cnt = live_cnt + LIVE_CNT_LEN'(below_th);

	always_ff @(posedge clk or negedge reset_N)
	begin
		if (!reset_N)
		begin
			found <= 1'b0;
			live_cnt <= '0;
			match_valid <= 1'b0;
			match_index <= '0;
			new_bbox <= 1'b0;
			conflict <= 1'b0;
		end
		else
		begin
			match_valid <= score_valid && score_last;
			if (score_valid)
			begin
				if (score_last)
				begin
					// report and clear for the next detection
					match_index <= nxt_found ? nxt_idx : '0;
					new_bbox <= !nxt_found || (nxt_score >= cfg.score_th_for_new_bbox);
					conflict <= (nxt_cnt >
						LIVE_CNT_LEN'(cfg.max_threshold_for_conflicts));
					found <= 1'b0;
					live_cnt <= '0;
				end
				else
				begin
					found <= nxt_found;
					live_cnt <= nxt_cnt;
				end
			end
		end
	end

	// best so far, only meaningful while found is set
	always_ff @(posedge clk)
	begin
		if (score_valid)
		begin
			best_score <= nxt_score;
			best_idx <= nxt_idx;
		end
	end

	// winner lies within the detection just closed
	a_index_range: assert property (@(posedge clk) disable iff (!reset_N)
		match_valid |-> (match_index <= $past(score_index)));

endmodule

`default_nettype wire

/* hw/oflow_core_top.sv */
//----------------------------------------------------------
// association core top level
// apb configuration, pair scoring and match selection
// no back-pressure, results arrive 3 cycles after pair_last
//----------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module oflow_core_top
	import oflow_reg_pkg::*;
	import oflow_bbox_pkg::*;
(
	input  logic                    clk,
	input  logic                    reset_N,
	// apb slave
	input  logic                    psel,
	input  logic                    penable,
	input  logic                    pwrite,
	input  logic [ADDR_LEN-1:0]     paddr,
	input  logic [DATA_LEN-1:0]     pwdata,
	output logic [DATA_LEN-1:0]     prdata,
	output logic                    pready,
	output logic                    pslverr,
	// candidate pairs
	input  logic                    pair_valid,
	input  logic                    pair_last,
	input  logic [FEATURE_LEN-1:0]  cur_w,
	input  logic [FEATURE_LEN-1:0]  cur_h,
	input  logic [FEATURE_LEN-1:0]  cur_c1,
	input  logic [FEATURE_LEN-1:0]  cur_c2,
	input  logic [FEATURE_LEN-1:0]  prev_w,
	input  logic [FEATURE_LEN-1:0]  prev_h,
	input  logic [FEATURE_LEN-1:0]  prev_c1,
	input  logic [FEATURE_LEN-1:0]  prev_c2,
	input  logic [FEATURE_LEN-1:0]  iou_cost,
	input  logic [FEATURE_LEN-1:0]  hist_age,
	// per-detection result
	output logic                    match_valid,
	output logic [CAND_IDX_LEN-1:0] match_index,
	output logic                    new_bbox,
	output logic                    conflict
);

	// scorer to selector
	logic score_valid;
	logic score_last;
	logic [SCORE_LEN-1:0] score;
	logic expired;
	logic [CAND_IDX_LEN-1:0] score_index;

	oflow_weights_if cfg_if ();

	oflow_reg_file reg_file_i (
		.clk(clk), .reset_N(reset_N),
		.apb_psel(psel), .apb_penable(penable), .apb_pwrite(pwrite),
		.apb_addr(paddr), .apb_pwdata(pwdata), .apb_prdata(prdata),
		.apb_pready(pready), .apb_pslverr(pslverr),
		.cfg(cfg_if.reg_side)
	);

	oflow_score_calc score_calc_i (
		.clk(clk), .reset_N(reset_N),
		.pair_valid(pair_valid), .pair_last(pair_last),
		.cur_w(cur_w), .cur_h(cur_h), .cur_c1(cur_c1), .cur_c2(cur_c2),
		.prev_w(prev_w), .prev_h(prev_h), .prev_c1(prev_c1), .prev_c2(prev_c2),
		.iou_cost(iou_cost), .hist_age(hist_age),
		.cfg(cfg_if.core_side),
		.score_valid(score_valid), .score_last(score_last), .score(score),
		.expired(expired), .score_index(score_index)
	);

	oflow_match_select match_select_i (
		.clk(clk), .reset_N(reset_N),
		.score_valid(score_valid), .score_last(score_last), .score(score),
		.expired(expired), .score_index(score_index),
		.cfg(cfg_if.core_side),
		.match_valid(match_valid), .match_index(match_index),
		.new_bbox(new_bbox), .conflict(conflict)
	);

endmodule

`default_nettype wire

/* include/oflow_tb_model.svh */
//----------------------------------------------------------
// reference model for the association core testbench
// include inside a module that imports both packages
// lfsr is 32-bit fibonacci, taps 32 22 2 1
// selection assumes at most 16 candidates per detection
//----------------------------------------------------------
`ifndef OFLOW_TB_MODEL_SVH
`define OFLOW_TB_MODEL_SVH

// one shift, the new bit enters at bit 0
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
	return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// field mask of a mapped register, zero off the map
function automatic logic [31:0] reg_mask(input logic [ADDR_LEN-1:0] addr);
	case (addr)
		W_IOU_ADDR, W_WIDTH_ADDR, W_HEIGHT_ADDR,
		W_COLOR1_ADDR, W_COLOR2_ADDR, W_HISTORY_ADDR:
			return 32'h0000_00ff;
		SCORE_TH_FOR_NEW_BBOX_ADDR:
			return 32'h000f_ffff;
		NUM_OF_HISTORY_FRAMES_ADDR:
			return 32'h0000_00ff;
		MAX_THRESHOLD_FOR_CONFLICTS_ADDR:
			return 32'h0000_000f;
		default:
			return 32'h0000_0000;
	endcase
endfunction

// distance between two unsigned features
function automatic int feature_gap(input logic [7:0] a, input logic [7:0] b);
	int d;
	d = int'(a) - int'(b);
	return (d < 0) ? -d : d;
endfunction

// six weighted terms of one pair
function automatic logic [SCORE_LEN-1:0] ref_score(
	input logic [7:0] w_iou, w_w, w_h, w_c1, w_c2, w_hist,
	input logic [7:0] cw, ch, cc1, cc2, pw, ph, pc1, pc2, iou, age
);
	int sum;
	sum = int'(w_w) * feature_gap(cw, pw) + int'(w_h) * feature_gap(ch, ph);
	sum = sum + int'(w_c1) * feature_gap(cc1, pc1) + int'(w_c2) * feature_gap(cc2, pc2);
	sum = sum + int'(w_iou) * int'(iou) + int'(w_hist) * int'(age);
	return SCORE_LEN'(sum);
endfunction

// packed result, index in [5:2], new track in [1], conflict in [0]
function automatic logic [5:0] ref_select(
	input logic [SCORE_LEN-1:0] sc [16],
	input bit lv [16],
	input int n,
	input logic [SCORE_LEN-1:0] th,
	input logic [3:0] max_conf
);
	int k;
	int best_k;
	int n_below;
	bit any_live;
	bit nb;
	bit cf;
	logic [SCORE_LEN-1:0] best;
	best_k = 0;
	n_below = 0;
	any_live = 1'b0;
	best = '0;
	for (k = 0; k < n; k++)
	begin
		if (lv[k[3:0]])
		begin
			// first live one, or strictly better
			if (!any_live || sc[k[3:0]] < best)
			begin
				best = sc[k[3:0]];
				best_k = k;
			end
			any_live = 1'b1;
			if (sc[k[3:0]] < th)
				n_below++;
		end
	end
	nb = !any_live || (best >= th);
	cf = n_below > int'(max_conf);
	return {best_k[3:0], nb, cf};
endfunction

`endif

/* tests/oflow_tb.sv */
//----------------------------------------------------------
// association core testbench, random detections per round
// weights change only with no pairs in flight
// expected results come from the model in the include file
//----------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module oflow_tb
	import oflow_reg_pkg::*;
	import oflow_bbox_pkg::*;
();

	localparam logic [31:0] LFSR_SEED = 32'had34_ae44;
	localparam int NUM_ROUNDS = 10;
	localparam int DETS_PER_ROUND = 20;
	localparam int NUM_EXPIRED_DETS = 4;
	localparam int NUM_DETECTIONS = NUM_ROUNDS * DETS_PER_ROUND + NUM_EXPIRED_DETS;
	localparam int WATCHDOG_CYCLES = NUM_DETECTIONS * 40 + 500;

	logic clk;
	logic reset_N;
	logic psel;
	logic penable;
	logic pwrite;
	logic [ADDR_LEN-1:0] paddr;
	logic [DATA_LEN-1:0] pwdata;
	logic [DATA_LEN-1:0] prdata;
	logic pready;
	logic pslverr;
	logic pair_valid;
	logic pair_last;
	logic [FEATURE_LEN-1:0] cur_w;
	logic [FEATURE_LEN-1:0] cur_h;
	logic [FEATURE_LEN-1:0] cur_c1;
	logic [FEATURE_LEN-1:0] cur_c2;
	logic [FEATURE_LEN-1:0] prev_w;
	logic [FEATURE_LEN-1:0] prev_h;
	logic [FEATURE_LEN-1:0] prev_c1;
	logic [FEATURE_LEN-1:0] prev_c2;
	logic [FEATURE_LEN-1:0] iou_cost;
	logic [FEATURE_LEN-1:0] hist_age;
	logic match_valid;
	logic [CAND_IDX_LEN-1:0] match_index;
	logic new_bbox;
	logic conflict;

	// register shadow, indexed by word address
	logic [DATA_LEN-1:0] shadow [16];
	logic [31:0] lfsr;
	// expected results in detection order
	logic [5:0] exp_q [$];
	logic [5:0] head_exp = 6'd0;
	bit head_ok = 1'b0;
	int det_sent = 0;
	int results_seen = 0;

	`include "oflow_tb_model.svh"

	oflow_core_top dut_i (.*);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Done: errors found");
		$fatal(1);
	endtask

	// one lfsr step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		int k;
		v = '0;
		for (k = 0; k < n; k++)
		begin
			lfsr = lfsr_step(lfsr);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	//----------------------------------------------------------
	// apb accesses, setup then access phase
	//----------------------------------------------------------
	task automatic apb_write(input logic [ADDR_LEN-1:0] addr, input logic [DATA_LEN-1:0] data);
		@(posedge clk);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= 1'b1;
		paddr <= addr;
		pwdata <= data;
		@(posedge clk);
		penable <= 1'b1;
		@(posedge clk);
		psel <= 1'b0;
		penable <= 1'b0;
		// register takes the write at this same edge
		if (reg_mask(addr) != 32'd0)
			shadow[addr[5:2]] = data & reg_mask(addr);
	endtask

	task automatic apb_read(input logic [ADDR_LEN-1:0] addr);
		logic [DATA_LEN-1:0] exp_val;
		exp_val = (reg_mask(addr) != 32'd0) ? shadow[addr[5:2]] : 32'd0;
		@(posedge clk);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= 1'b0;
		paddr <= addr;
		@(posedge clk);
		penable <= 1'b1;
		// prdata settled mid access phase
		@(negedge clk);
		assert (prdata == exp_val)
		else
			abort_run($sformatf("ERR %0t: read of %0h gave %0h, expected %0h",
				$time, addr, prdata, exp_val));
		@(posedge clk);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic check_all_regs();
		int k;
		for (k = 0; k < NUM_REGS; k++)
			apb_read(ADDR_LEN'(k * 4));
	endtask

	// random upper bits exercise truncation
	task automatic program_round(input int r);
		logic [DATA_LEN-1:0] th_data;
		logic [DATA_LEN-1:0] conf_data;
		int k;
		th_data = rand_bits(32) & 32'hfff0_ffff;
		conf_data = rand_bits(32);
		if (r == 0)
			conf_data = conf_data & 32'hffff_fff0;
		else if (r == 1)
		begin
			th_data = 32'hffff_ffff;
			conf_data = conf_data | 32'h0000_000f;
		end
		else if (r == 2)
			th_data = 32'hfff0_0000;
		for (k = 0; k < 6; k++)
			apb_write(ADDR_LEN'(k * 4), rand_bits(32));
		apb_write(SCORE_TH_FOR_NEW_BBOX_ADDR, th_data);
		// frame limit 64 to 127, ages run 0 to 127
		apb_write(NUM_OF_HISTORY_FRAMES_ADDR, (rand_bits(32) & 32'hffff_ff7f) | 32'h40);
		apb_write(MAX_THRESHOLD_FOR_CONFLICTS_ADDR, conf_data);
	endtask

	task automatic probe_unmapped();
		logic [ADDR_LEN-1:0] a;
		a = ADDR_LEN'(rand_bits(8));
		// mapped words sit on multiples of four
		if (reg_mask(a) != 32'd0)
			a = a | 8'h01;
		apb_write(a, rand_bits(32));
		apb_read(a);
	endtask

	//----------------------------------------------------------
	// pair stimulus
	//----------------------------------------------------------
	task automatic send_detection(input bit all_expired);
		int n;
		int i;
		int j;
		logic [7:0] cw;
		logic [7:0] ch;
		logic [7:0] cc1;
		logic [7:0] cc2;
		logic [7:0] pw [16];
		logic [7:0] ph [16];
		logic [7:0] pc1 [16];
		logic [7:0] pc2 [16];
		logic [7:0] iou [16];
		logic [7:0] age [16];
		logic [SCORE_LEN-1:0] sc [16];
		bit lv [16];
		n = 1 + int'(rand_bits(4));
		cw = 8'(rand_bits(8));
		ch = 8'(rand_bits(8));
		cc1 = 8'(rand_bits(8));
		cc2 = 8'(rand_bits(8));
		for (i = 0; i < 16; i++)
		begin
			lv[i[3:0]] = 1'b0;
			sc[i[3:0]] = '0;
		end
		for (i = 0; i < n; i++)
		begin
			// repeat an earlier candidate to force a tie
			if (i > 0 && rand_bits(2) == 32'd0)
			begin
				j = int'(rand_bits(4)) % i;
				pw[i[3:0]] = pw[j[3:0]];
				ph[i[3:0]] = ph[j[3:0]];
				pc1[i[3:0]] = pc1[j[3:0]];
				pc2[i[3:0]] = pc2[j[3:0]];
				iou[i[3:0]] = iou[j[3:0]];
				age[i[3:0]] = age[j[3:0]];
			end
			else
			begin
				pw[i[3:0]] = 8'(rand_bits(8));
				ph[i[3:0]] = 8'(rand_bits(8));
				pc1[i[3:0]] = 8'(rand_bits(8));
				pc2[i[3:0]] = 8'(rand_bits(8));
				iou[i[3:0]] = 8'(rand_bits(8));
				age[i[3:0]] = all_expired ? 8'd200 + 8'(rand_bits(5)) : 8'(rand_bits(7));
			end
			sc[i[3:0]] = ref_score(shadow[0][7:0], shadow[1][7:0], shadow[2][7:0],
				shadow[3][7:0], shadow[4][7:0], shadow[5][7:0], cw, ch, cc1, cc2,
				pw[i[3:0]], ph[i[3:0]], pc1[i[3:0]], pc2[i[3:0]], iou[i[3:0]], age[i[3:0]]);
			lv[i[3:0]] = age[i[3:0]] < shadow[7][7:0];
		end
		exp_q.push_back(ref_select(sc, lv, n, shadow[6][SCORE_LEN-1:0], shadow[8][3:0]));
		det_sent++;
		for (i = 0; i < n; i++)
		begin
			@(posedge clk);
			pair_valid <= 1'b1;
			pair_last <= (i == n - 1);
			cur_w <= cw;
			cur_h <= ch;
			cur_c1 <= cc1;
			cur_c2 <= cc2;
			prev_w <= pw[i[3:0]];
			prev_h <= ph[i[3:0]];
			prev_c1 <= pc1[i[3:0]];
			prev_c2 <= pc2[i[3:0]];
			iou_cost <= iou[i[3:0]];
			hist_age <= age[i[3:0]];
		end
	endtask

	// stop the pair stream and wait for every result
	task automatic drain_pairs();
		@(posedge clk);
		pair_valid <= 1'b0;
		pair_last <= 1'b0;
		while (exp_q.size() != 0)
			@(posedge clk);
	endtask

	//----------------------------------------------------------
	// scoreboard and checks
	//----------------------------------------------------------
	always @(posedge clk)
	begin
		if (reset_N && match_valid && exp_q.size() != 0)
		begin
			void'(exp_q.pop_front());
			results_seen++;
		end
		head_ok <= (exp_q.size() != 0);
		head_exp <= (exp_q.size() != 0) ? exp_q[0] : 6'd0;
	end

	a_result: assert property (@(posedge clk) disable iff (!reset_N)
		match_valid |-> (head_ok && ({match_index, new_bbox, conflict} == head_exp)))
		else abort_run($sformatf("ERR %0t: index %0d new %0b conflict %0b, expected %0h ok %0b",
			$time, $sampled(match_index), $sampled(new_bbox), $sampled(conflict),
			$sampled(head_exp), $sampled(head_ok)));

	// zero wait states, slave error only off the map
	a_apb_access: assert property (@(posedge clk) disable iff (!reset_N)
		(psel && penable) |-> (pready && (pslverr == (reg_mask(paddr) == 32'd0))
			&& (!pwrite || prdata == 32'd0)))
		else abort_run($sformatf("ERR %0t: access to %0h pready %0b pslverr %0b prdata %0h",
			$time, $sampled(paddr), $sampled(pready), $sampled(pslverr), $sampled(prdata)));

	a_apb_idle: assert property (@(posedge clk) disable iff (!reset_N)
		!(psel && penable) |-> (!pready && !pslverr && (prdata == 32'd0)))
		else abort_run($sformatf("ERR %0t: apb outputs active outside an access", $time));

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		abort_run($sformatf("timeout, %0d detections sent but only %0d results arrived",
			det_sent, results_seen));
	end

	initial
	begin
		int r;
		int d;
		reset_N <= 1'b0;
		psel <= 1'b0;
		penable <= 1'b0;
		pwrite <= 1'b0;
		paddr <= '0;
		pwdata <= '0;
		pair_valid <= 1'b0;
		pair_last <= 1'b0;
		{cur_w, cur_h, cur_c1, cur_c2} <= '0;
		{prev_w, prev_h, prev_c1, prev_c2} <= '0;
		iou_cost <= '0;
		hist_age <= '0;
		lfsr = LFSR_SEED;
		for (r = 0; r < 16; r++)
			shadow[r[3:0]] = '0;
		repeat (10) @(posedge clk);
		reset_N <= 1'b1;
		@(posedge clk);
		assert (!pready && !pslverr && !match_valid && !dut_i.score_valid)
		else
			abort_run($sformatf("ERR %0t: outputs not idle after reset", $time));
		check_all_regs();
		for (r = 0; r < NUM_ROUNDS; r++)
		begin
			program_round(r);
			check_all_regs();
			probe_unmapped();
			check_all_regs();
			// detections back to back
			for (d = 0; d < DETS_PER_ROUND; d++)
				send_detection(1'b0);
			drain_pairs();
		end
		// every candidate too old
		apb_write(NUM_OF_HISTORY_FRAMES_ADDR, 32'h0000_00c8);
		for (d = 0; d < NUM_EXPIRED_DETS; d++)
			send_detection(1'b1);
		drain_pairs();
		$display("Done: no errors");
		$finish;
	end

endmodule

`default_nettype wire

/* tb.f */
+incdir+include
hw/oflow_reg_pkg.sv
hw/oflow_bbox_pkg.sv
hw/oflow_weights_if.sv
hw/oflow_reg_file.sv
hw/oflow_score_calc.sv
hw/oflow_match_select.sv
hw/oflow_core_top.sv
tests/oflow_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the association core testbench with verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
	--top-module oflow_tb -f tb.f -o oflow_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/oflow_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "Done: errors found" "$LOG"; then
	echo "simulation reported failure"
	exit 1
fi
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi
echo "simulation passed"
exit 0
